// ==== design/p2a_pkg.sv ====
// p2a translation package holding the BAR count, widths, config field codes and the shared structs
`default_nettype none

package p2a_pkg;

  // six memory BARs plus the expansion ROM BAR
  parameter int NUM_BARS = 7;

  // PCIe and Avalon addresses are both 32 bits wide
  parameter int ADDR_W = 32;

  // request tag carried alongside the address to the output
  parameter int TAG_W = 8;

  // wide enough to index every BAR unit
  parameter int BAR_IDX_W = 3;

  // the low mask bits hold BAR flags and never take part in a match
  parameter int MASK_LSB = 4;

  // selects which register of a BAR a configuration write lands in
  typedef enum logic [1:0] {
    CFG_MASK = 2'd0,
    CFG_BASE = 2'd1,
    CFG_AVL  = 2'd2
  } cfg_field_e;

  // inbound request whose valid is a single-cycle strobe
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
  } p2a_req_t;

  // per-BAR view that the translator needs
  // mask bits 31 down to 4 mark the translated part of the address
  typedef struct packed {
    logic [ADDR_W-1:0] mask;
    logic [ADDR_W-1:0] avl;
  } bar_cfg_t;

  // translated result leaving the block
  // on a miss the address and the hit index are both zero
  typedef struct packed {
    logic                 valid;
    logic [TAG_W-1:0]     tag;
    logic [ADDR_W-1:0]    avl_addr;
    logic                 miss;
    logic [BAR_IDX_W-1:0] hit_idx;
  } p2a_xlat_t;

endpackage

`default_nettype wire

// ==== design/p2a_req_capture.sv ====
// p2a request capture registers inbound requests and turns config writes into per-BAR strobes
`timescale 1ns/1ps
`default_nettype none

module p2a_req_capture #(
  parameter int NUM_BARS = p2a_pkg::NUM_BARS
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  p2a_pkg::p2a_req_t              req_i,
  input  logic                           cfg_we_i,
  input  logic [p2a_pkg::BAR_IDX_W-1:0]  cfg_bar_i,
  input  p2a_pkg::cfg_field_e            cfg_field_i,
  input  logic [p2a_pkg::ADDR_W-1:0]     cfg_data_i,
  output p2a_pkg::p2a_req_t              req_o,
  output logic [NUM_BARS-1:0]            cfg_we_o,
  output p2a_pkg::cfg_field_e            cfg_field_o,
  output logic [p2a_pkg::ADDR_W-1:0]     cfg_data_o
);

  import p2a_pkg::*;

  logic                req_vld_q;
  logic [TAG_W-1:0]    req_tag_q;
  logic [ADDR_W-1:0]   req_addr_q;
  logic [NUM_BARS-1:0] we_dec;
  logic [NUM_BARS-1:0] we_q;
  cfg_field_e          field_q;
  logic [ADDR_W-1:0]   data_q;

  // decode the BAR index into a one-hot strobe
  // an index past the last BAR matches no slot and so writes nothing
  always_comb
  begin
    we_dec = '0;
    for (int i = 0; i < NUM_BARS; i++)
    begin
      we_dec[i] = cfg_we_i && (cfg_bar_i == BAR_IDX_W'(i));
    end
  end

  // request valid and the decoded write strobes are registered every cycle
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      req_vld_q <= 1'b0;
      we_q      <= '0;
    end
    else
    begin
      req_vld_q <= req_i.valid;
      we_q      <= we_dec;
    end
  end

  // tag and address are sampled on every edge and only mean something while valid is set
  always_ff @(posedge clk_i)
  begin
    req_tag_q  <= req_i.tag;
    req_addr_q <= req_i.addr;
    // config payload only moves on a write so the units see a stable word
    if (cfg_we_i)
    begin
      field_q <= cfg_field_i;
      data_q  <= cfg_data_i;
    end
  end

  assign req_o.valid = req_vld_q;
  assign req_o.tag   = req_tag_q;
  assign req_o.addr  = req_addr_q;
  assign cfg_we_o    = we_q;
  assign cfg_field_o = field_q;
  assign cfg_data_o  = data_q;

  // a write aimed past the last BAR would silently disappear
  a_cfg_bar_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_we_i |-> (int'(cfg_bar_i) < NUM_BARS));

endmodule

`default_nettype wire

// ==== design/p2a_bar_unit.sv ====
// p2a BAR unit holds one window's mask, base and Avalon entry and registers its hit flag
`timescale 1ns/1ps
`default_nettype none

module p2a_bar_unit (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  p2a_pkg::p2a_req_t          req_i,
  input  logic                       cfg_we_i,
  input  p2a_pkg::cfg_field_e        cfg_field_i,
  input  logic [p2a_pkg::ADDR_W-1:0] cfg_data_i,
  output logic                       hit_o,
  output p2a_pkg::p2a_req_t          req_o,
  output p2a_pkg::bar_cfg_t          bar_cfg_o
);

  import p2a_pkg::*;

  logic [ADDR_W-1:0] mask_q;
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] avl_q;
  logic [ADDR_W-1:0] mask_eff;
  logic [ADDR_W-1:0] mask_inv;
  logic              match;
  logic              hit_q;
  logic              req_vld_q;
  logic [TAG_W-1:0]  req_tag_q;
  logic [ADDR_W-1:0] req_addr_q;

  // flag bits below MASK_LSB are dropped before any compare
  assign mask_eff = {mask_q[ADDR_W-1:MASK_LSB], {MASK_LSB{1'b0}}};
  assign mask_inv = ~mask_eff;

  // the window is open only with a nonzero mask
  // inside it the address and the base agree on every masked bit
  assign match = (|mask_eff) && (((req_i.addr ^ base_q) & mask_eff) == '0);

  // all three BAR words come up cleared so the window starts closed
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mask_q <= '0;
      base_q <= '0;
      avl_q  <= '0;
    end
    else if (cfg_we_i)
    begin
      case (cfg_field_i)
        CFG_MASK: mask_q <= cfg_data_i;
        CFG_BASE: base_q <= cfg_data_i;
        CFG_AVL:  avl_q  <= cfg_data_i;
        default:  ;
      endcase
    end
  end

  // hit is registered together with the request valid it belongs to
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hit_q     <= 1'b0;
      req_vld_q <= 1'b0;
    end
    else
    begin
      hit_q     <= req_i.valid && match;
      req_vld_q <= req_i.valid;
    end
  end

  // tag and address ride along one stage so they line up with hit_o
  always_ff @(posedge clk_i)
  begin
    req_tag_q  <= req_i.tag;
    req_addr_q <= req_i.addr;
  end

  assign hit_o          = hit_q;
  assign req_o.valid    = req_vld_q;
  assign req_o.tag      = req_tag_q;
  assign req_o.addr     = req_addr_q;
  assign bar_cfg_o.mask = mask_q;
  assign bar_cfg_o.avl  = avl_q;

  // a legal window is a power-of-two size, so its mask is ones from bit 31 down
  // then the inverted mask plus one carries into a single clear bit
  a_mask_contig : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mask_inv & (mask_inv + 1'b1)) == '0);

endmodule

`default_nettype wire

// ==== design/p2a_addrtrans.sv ====
// p2a address translator picks the hit BAR's entry and merges it with the PCIe address
`timescale 1ns/1ps
`default_nettype none

module p2a_addrtrans #(
  parameter int NUM_BARS = p2a_pkg::NUM_BARS
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [NUM_BARS-1:0]   hit_i,
  input  p2a_pkg::p2a_req_t     req_i,
  input  p2a_pkg::bar_cfg_t     bar_cfg_i [NUM_BARS],
  output p2a_pkg::p2a_xlat_t    xlat_o
);

  import p2a_pkg::*;

  logic [ADDR_W-1:0]    mask_sel;
  logic [ADDR_W-1:0]    avl_sel;
  logic [BAR_IDX_W-1:0] idx_sel;
  logic [ADDR_W-1:0]    mask_eff;
  logic [ADDR_W-1:0]    merged;
  logic                 one_hot;
  logic                 xlat_vld_q;
  logic                 miss_q;
  logic [TAG_W-1:0]     tag_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [BAR_IDX_W-1:0] idx_q;

  // and-or mux over the hit vector
  // with exactly one bit set this is the plain selection of that BAR
  always_comb
  begin
    mask_sel = '0;
    avl_sel  = '0;
    idx_sel  = '0;
    for (int i = 0; i < NUM_BARS; i++)
    begin
      if (hit_i[i])
      begin
        mask_sel = mask_sel | bar_cfg_i[i].mask;
        avl_sel  = avl_sel | bar_cfg_i[i].avl;
        idx_sel  = idx_sel | BAR_IDX_W'(i);
      end
    end
  end

  // clearing the lowest set bit leaves nothing only for a single hit
  assign one_hot = (hit_i != '0) && ((hit_i & (hit_i - 1'b1)) == '0);

  // BAR flag bits are forced to zero so the low nibble always passes through
  assign mask_eff = {mask_sel[ADDR_W-1:MASK_LSB], {MASK_LSB{1'b0}}};

  // high bits come from the table entry, low bits from the PCIe address
  assign merged = (req_i.addr & ~mask_eff) | (avl_sel & mask_eff);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      xlat_vld_q <= 1'b0;
      miss_q     <= 1'b0;
    end
    else
    begin
      xlat_vld_q <= req_i.valid;
      // no hit or an overlap of windows both count as a miss
      miss_q     <= req_i.valid && !one_hot;
    end
  end

  // the result payload is zeroed on a miss so a stale entry never leaks out
  always_ff @(posedge clk_i)
  begin
    tag_q  <= req_i.tag;
    addr_q <= one_hot ? merged : '0;
    idx_q  <= one_hot ? idx_sel : '0;
  end

  assign xlat_o.valid    = xlat_vld_q;
  assign xlat_o.tag      = tag_q;
  assign xlat_o.avl_addr = addr_q;
  assign xlat_o.miss     = miss_q;
  assign xlat_o.hit_idx  = idx_q;

  // a double hit from the BAR units can only come with a valid request
  // and it has to leave next cycle as a miss
  a_overlap_miss : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($countones(hit_i) > 1) |=> (xlat_o.valid && xlat_o.miss));

endmodule

`default_nettype wire

// ==== design/p2a_xlat_top.sv ====
// p2a translation top wires the capture stage to one unit per BAR and to the address translator
`timescale 1ns/1ps
`default_nettype none

module p2a_xlat_top #(
  parameter int NUM_BARS = p2a_pkg::NUM_BARS
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  p2a_pkg::p2a_req_t              req_i,
  input  logic                           cfg_we_i,
  input  logic [p2a_pkg::BAR_IDX_W-1:0]  cfg_bar_i,
  input  p2a_pkg::cfg_field_e            cfg_field_i,
  input  logic [p2a_pkg::ADDR_W-1:0]     cfg_data_i,
  output p2a_pkg::p2a_xlat_t             xlat_o
);

  import p2a_pkg::*;

  // capture stage outputs
  p2a_req_t            cap_req;
  logic [NUM_BARS-1:0] cap_we;
  cfg_field_e          cap_field;
  logic [ADDR_W-1:0]   cap_data;

  // BAR stage outputs, one slot per unit
  logic [NUM_BARS-1:0] bar_hit;
  p2a_req_t            bar_req [NUM_BARS];
  bar_cfg_t            bar_cfg [NUM_BARS];

  p2a_req_capture #(
    .NUM_BARS (NUM_BARS)
  ) p2a_req_capture_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_bar_i   (cfg_bar_i),
    .cfg_field_i (cfg_field_i),
    .cfg_data_i  (cfg_data_i),
    .req_o       (cap_req),
    .cfg_we_o    (cap_we),
    .cfg_field_o (cap_field),
    .cfg_data_o  (cap_data)
  );

  // every unit sees the same request and config word but only its own strobe
  for (genvar i = 0; i < NUM_BARS; i++)
  begin : g_bar
    p2a_bar_unit p2a_bar_unit_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (cap_req),
      .cfg_we_i    (cap_we[i]),
      .cfg_field_i (cap_field),
      .cfg_data_i  (cap_data),
      .hit_o       (bar_hit[i]),
      .req_o       (bar_req[i]),
      .bar_cfg_o   (bar_cfg[i])
    );
  end

  // unit 0 supplies the tag and address that travel with the hit vector
  p2a_addrtrans #(
    .NUM_BARS (NUM_BARS)
  ) p2a_addrtrans_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .hit_i     (bar_hit),
    .req_i     (bar_req[0]),
    .bar_cfg_i (bar_cfg),
    .xlat_o    (xlat_o)
  );

endmodule

`default_nettype wire

// ==== verification/p2a_xlat_checker.sv ====
// p2a translation checker matches every DUT result against the expected record queued for it
`timescale 1ns/1ps
`default_nettype none

module p2a_xlat_checker #(
  parameter int LATENCY = 3
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  p2a_pkg::p2a_xlat_t            xlat_i,
  input  logic                          exp_vld_i,
  input  logic [127:0]                  exp_name_i,
  input  logic [p2a_pkg::TAG_W-1:0]     exp_tag_i,
  input  logic                          exp_miss_i,
  input  logic [p2a_pkg::BAR_IDX_W-1:0] exp_idx_i,
  input  logic [p2a_pkg::ADDR_W-1:0]    exp_addr_i,
  input  logic                          end_i,
  output int                            pass_cnt_o,
  output int                            fail_cnt_o,
  output int                            pending_o,
  output logic                          done_o
);

  import p2a_pkg::*;

  // due is the cycle on which the result has to show up
  typedef struct packed {
    logic [127:0]         name;
    logic [TAG_W-1:0]     tag;
    logic                 miss;
    logic [BAR_IDX_W-1:0] idx;
    logic [ADDR_W-1:0]    addr;
    logic [31:0]          due;
  } exp_rec_t;

  exp_rec_t exp_q [$];
  int       cycle;
  int       pass_cnt;
  int       fail_cnt;

  initial
  begin
    cycle    = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    done_o   = 1'b0;
  end

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;
  assign pending_o  = exp_q.size();

  always @(posedge clk_i)
    cycle <= cycle + 1;

  task automatic compare_field(input logic [127:0] name, input string what,
      input logic [31:0] exp_v, input logic [31:0] act_v, inout int errs);
    if (act_v !== exp_v)
    begin
      $display("[ERROR] %0s %0s expected %h actual %h", name, what, exp_v, act_v);
      errs++;
    end
  endtask

  task automatic finish_test(input logic [127:0] name, input int errs);
    if (errs == 0)
    begin
      pass_cnt++;
      $display("test %0s passed", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %0s failed", name);
    end
  endtask

  // outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge clk_i)
  begin
    exp_rec_t e;
    int       errs;
    if (rst_n_i)
    begin
      if (xlat_i.valid === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("unexpected output with empty queue, tag %h at cycle %0d", xlat_i.tag, cycle);
          fail_cnt++;
        end
        else
        begin
          e    = exp_q.pop_front();
          errs = 0;
          compare_field(e.name, "tag", 32'(e.tag), 32'(xlat_i.tag), errs);
          compare_field(e.name, "miss", 32'(e.miss), 32'(xlat_i.miss), errs);
          compare_field(e.name, "hit_idx", 32'(e.idx), 32'(xlat_i.hit_idx), errs);
          compare_field(e.name, "avl_addr", e.addr, xlat_i.avl_addr, errs);
          compare_field(e.name, "latency", 32'(LATENCY), 32'(cycle) - e.due + 32'(LATENCY), errs);
          finish_test(e.name, errs);
        end
      end
      // a head that is past due will never be matched
      while (exp_q.size() != 0 && exp_q[0].due < 32'(cycle))
      begin
        e = exp_q.pop_front();
        $display("test %0s produced no output by cycle %0d", e.name, e.due);
        finish_test(e.name, 1);
      end
      if (exp_vld_i)
      begin
        e.name = exp_name_i;
        e.tag  = exp_tag_i;
        e.miss = exp_miss_i;
        e.idx  = exp_idx_i;
        e.addr = exp_addr_i;
        e.due  = 32'(cycle + LATENCY);
        exp_q.push_back(e);
      end
      if (end_i && !done_o)
      begin
        while (exp_q.size() != 0)
        begin
          e = exp_q.pop_front();
          $display("test %0s was still waiting for its output at the end", e.name);
          finish_test(e.name, 1);
        end
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        done_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/p2a_xlat_tb.sv ====
// p2a translation testbench reads the stim file, drives the DUT and decides the run result
`timescale 1ns/1ps
`default_nettype none

module p2a_xlat_tb;

  import p2a_pkg::*;

  localparam string STIM_PATH  = "verification/p2a_xlat_stim.txt";
  localparam int    RST_CYCLES = 16;
  localparam int    WRITE_GAP  = 3;
  localparam int    LATENCY    = 3;

  logic                 clk;
  logic                 rst_n;
  p2a_req_t             req;
  logic                 cfg_we;
  logic [BAR_IDX_W-1:0] cfg_bar;
  cfg_field_e           cfg_field;
  logic [ADDR_W-1:0]    cfg_data;
  p2a_xlat_t            xlat;

  // expected record handed to the checker alongside each request strobe
  logic                 exp_vld;
  logic [127:0]         exp_name;
  logic [TAG_W-1:0]     exp_tag;
  logic                 exp_miss;
  logic [BAR_IDX_W-1:0] exp_idx;
  logic [ADDR_W-1:0]    exp_addr;
  logic                 end_run;
  logic                 report_done;
  int                   pass_cnt;
  int                   fail_cnt;
  int                   pending;
  int                   line_cnt;
  int                   bad_lines;
  logic                 lines_known;
  logic [31:0]          rng_state;

  // 100 ns period
  always #50 clk = ~clk;

  p2a_xlat_top #(
    .NUM_BARS (NUM_BARS)
  ) p2a_xlat_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .cfg_we_i    (cfg_we),
    .cfg_bar_i   (cfg_bar),
    .cfg_field_i (cfg_field),
    .cfg_data_i  (cfg_data),
    .xlat_o      (xlat)
  );

  p2a_xlat_checker #(
    .LATENCY (LATENCY)
  ) p2a_xlat_checker_inst (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .xlat_i     (xlat),
    .exp_vld_i  (exp_vld),
    .exp_name_i (exp_name),
    .exp_tag_i  (exp_tag),
    .exp_miss_i (exp_miss),
    .exp_idx_i  (exp_idx),
    .exp_addr_i (exp_addr),
    .end_i      (end_run),
    .pass_cnt_o (pass_cnt),
    .fail_cnt_o (fail_cnt),
    .pending_o  (pending),
    .done_o     (report_done)
  );

  // 32-bit xorshift with shifts of 13, 17 and 5
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // every drive lands 1 ns after the rising edge
  task automatic drive_idle();
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    cfg_we    = 1'b0;
    exp_vld   = 1'b0;
  endtask

  task automatic issue_write(input logic [BAR_IDX_W-1:0] bar, input logic [1:0] field,
      input logic [ADDR_W-1:0] data);
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    exp_vld   = 1'b0;
    cfg_we    = 1'b1;
    cfg_bar   = bar;
    cfg_field = cfg_field_e'(field);
    cfg_data  = data;
  endtask

  // the low nibble always passes through, so a random offset goes into both addresses
  task automatic issue_request(input logic [127:0] name, input logic [TAG_W-1:0] tag,
      input logic [ADDR_W-1:0] addr, input logic miss, input logic [BAR_IDX_W-1:0] idx,
      input logic [ADDR_W-1:0] avl);
    logic [3:0] off;
    rng_state = xorshift32(rng_state);
    off = rng_state[3:0];
    @(posedge clk);
    #1;
    cfg_we    = 1'b0;
    req.valid = 1'b1;
    req.tag   = tag;
    req.addr  = {addr[ADDR_W-1:4], off};
    exp_vld   = 1'b1;
    exp_name  = name;
    exp_tag   = tag;
    exp_miss  = miss;
    exp_idx   = idx;
    // a miss always reports address zero
    exp_addr  = miss ? avl : {avl[ADDR_W-1:4], off};
  endtask

  initial
  begin : drive_seq
    int                   fd;
    int                   got;
    string                line;
    byte                  kind;
    logic [BAR_IDX_W-1:0] w_bar;
    logic [1:0]           w_field;
    logic [ADDR_W-1:0]    w_data;
    logic [127:0]         r_name;
    logic [TAG_W-1:0]     r_tag;
    logic [ADDR_W-1:0]    r_addr;
    logic                 r_miss;
    logic [BAR_IDX_W-1:0] r_idx;
    logic [ADDR_W-1:0]    r_avl;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = '0;
    cfg_we      = 1'b0;
    cfg_bar     = '0;
    cfg_field   = CFG_MASK;
    cfg_data    = '0;
    exp_vld     = 1'b0;
    exp_name    = '0;
    exp_tag     = '0;
    exp_miss    = 1'b0;
    exp_idx     = '0;
    exp_addr    = '0;
    end_run     = 1'b0;
    line_cnt    = 0;
    bad_lines   = 0;
    lines_known = 1'b0;
    rng_state   = 32'd92;
    // first pass only sizes the watchdog
    fd = $fopen(STIM_PATH, "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        got = $fgets(line, fd);
        if (got > 0)
          line_cnt++;
      end
      $fclose(fd);
    end
    lines_known = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen(STIM_PATH, "r");
    if (fd == 0)
    begin
      $display("could not open %s for reading", STIM_PATH);
      bad_lines++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        got  = $fgets(line, fd);
        kind = 8'h00;
        if (line.len() > 0)
          kind = line.getc(0);
        // comment and blank lines fall through both branches
        if (kind == "W")
        begin
          got = $sscanf(line, "W %h %h %h", w_bar, w_field, w_data);
          if (got == 3)
          begin
            issue_write(w_bar, w_field, w_data);
            repeat (WRITE_GAP) drive_idle();
          end
          else
          begin
            $display("stim line could not be parsed as a write: %s", line);
            bad_lines++;
          end
        end
        else if (kind == "R")
        begin
          got = $sscanf(line, "R %s %h %h %h %h %h", r_name, r_tag, r_addr, r_miss, r_idx,
                        r_avl);
          if (got == 6)
            issue_request(r_name, r_tag, r_addr, r_miss, r_idx, r_avl);
          else
          begin
            $display("stim line could not be parsed as a request: %s", line);
            bad_lines++;
          end
        end
      end
      $fclose(fd);
    end
    drive_idle();
    while (pending != 0) @(posedge clk);
    // one more pipeline depth so a stray late result is still seen
    repeat (LATENCY) @(posedge clk);
    end_run = 1'b1;
    wait (report_done);
    if (fail_cnt == 0 && bad_lines == 0 && pass_cnt > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // budget of eight cycles per stim line plus a fixed margin
  initial
  begin : watchdog
    wait (lines_known);
    repeat (line_cnt * 8 + 100) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", line_cnt * 8 + 100);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/p2a_xlat_stim.txt ====
# W <bar> <field 0=mask 1=base 2=avl> <data>                            all hex
# R <test> <tag> <pcie addr> <exp miss> <exp hit idx> <exp avl addr>    hex except test
R rst_miss_a 01 10000000 1 0 00000000
R rst_miss_b 02 6abcdef0 1 0 00000000
R rst_miss_c 03 00000000 1 0 00000000
W 0 0 fffffff0
W 0 1 10000000
W 0 2 a0000000
W 1 0 fffff008
W 1 1 20001000
W 1 2 b0005000
W 2 0 ffff0000
W 2 1 30010000
W 2 2 c0020000
W 3 0 fff00000
W 3 1 40100000
W 3 2 01200000
W 4 0 ff000000
W 4 1 55000000
W 4 2 7e000000
W 5 0 f0000000
W 5 1 60000000
W 5 2 80000000
W 6 0 fffe0000
W 6 1 70040000
W 6 2 0f0a0000
R bar0_16b 10 10000000 0 0 a0000000
R bar1_4k 11 20001ab0 0 1 b0005ab0
R bar2_64k 12 30012340 0 2 c0022340
R bar3_1m 13 401abcd0 0 3 012abcd0
R bar4_16m 14 55123450 0 4 7e123450
R bar5_256m 15 6abcdef0 0 5 8abcdef0
R rom_128k 16 70056780 0 6 0f0b6780
R bar3_top 17 401ffff0 0 3 012ffff0
R bar5_top 18 6ffffff0 0 5 8ffffff0
R bar0_edge 19 10000010 1 0 00000000
R no_window 1a 90000000 1 0 00000000
W 2 2 d0030000
R bar2_new 20 30012340 0 2 d0032340
R bar1_same 21 20001ab0 0 1 b0005ab0
R bar3_same 22 401abcd0 0 3 012abcd0
R bar4_same 23 55123450 0 4 7e123450
W 6 1 55000000
R overlap 24 55010000 1 0 00000000
R bar4_only 25 55123450 0 4 7e123450

// ==== files.f ====
design/p2a_pkg.sv
design/p2a_req_capture.sv
design/p2a_bar_unit.sv
design/p2a_addrtrans.sv
design/p2a_xlat_top.sv
verification/p2a_xlat_checker.sv
verification/p2a_xlat_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the translation testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module p2a_xlat_tb -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vp2a_xlat_tb)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run passes only if the testbench printed the pass line
if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi
